/* Makefile */
SIM = obj_dir/VdemodOutputTb

$(SIM): verilog.f $(wildcard hdl/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --top-module demodOutputTb -f verilog.f -o VdemodOutputTb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* hdl/adcReclock.sv */
`timescale 1ns/1ps

module adcReclock (
    input  logic               clk,
    input  demodPkg::adcCode_t adc,
    output demodPkg::sample_t  sample
);
    import demodPkg::*;

    adcCode_t adcReg;   // Capture at the pins

    always_ff @(posedge clk) begin
        adcReg <= adc;
    end

    // Offset binary to two's complement, left justified in 18 bits
    always_ff @(posedge clk) begin
        sample <= $signed({~adcReg[13], adcReg[12:0], 4'b0000});
    end

endmodule

/* hdl/busDecoder.sv */
`timescale 1ns/1ps

module busDecoder (
    input  demodPkg::regAddr_t addr,
    input  demodPkg::busData_t wrData,
    input  logic [3:0]         byteWr,
    input  logic               cs,
    output demodPkg::busData_t rdData,
    regPort.decoder            topPort,
    regPort.decoder            cd0Port,
    regPort.decoder            cd1Port,
    regPort.decoder            dac0Port,
    regPort.decoder            dac1Port
);
    import demodPkg::*;

    logic [8:0] space;
    logic [3:0] offset;

    assign space = addr[12:4];
    assign offset = addr[3:0];

    // Space decode
    assign topPort.sel = cs && (space == TOP_SPACE);
    assign cd0Port.sel = cs && (space == CANDD0_SPACE);
    assign cd1Port.sel = cs && (space == CANDD1_SPACE);
    assign dac0Port.sel = cs && (space == DAC0_SPACE);
    assign dac1Port.sel = cs && (space == DAC1_SPACE);

    // Offset and write fields fan out to every slave
    assign topPort.offset = offset;
    assign topPort.wrData = wrData;
    assign topPort.byteWr = byteWr;
    assign cd0Port.offset = offset;
    assign cd0Port.wrData = wrData;
    assign cd0Port.byteWr = byteWr;
    assign cd1Port.offset = offset;
    assign cd1Port.wrData = wrData;
    assign cd1Port.byteWr = byteWr;
    assign dac0Port.offset = offset;
    assign dac0Port.wrData = wrData;
    assign dac0Port.byteWr = byteWr;
    assign dac1Port.offset = offset;
    assign dac1Port.wrData = wrData;
    assign dac1Port.byteWr = byteWr;

    //*********************************************************************
    // Read data mux
    //*********************************************************************
    always_comb begin
        rdData = '0;
        if (cs) begin
            case (space)
                TOP_SPACE:    rdData = topPort.rdData;
                CANDD0_SPACE: rdData = cd0Port.rdData;
                CANDD1_SPACE: rdData = cd1Port.rdData;
                DAC0_SPACE:   rdData = dac0Port.rdData;
                DAC1_SPACE:   rdData = dac1Port.rdData;
                default:      rdData = '0;  // Unmapped space
            endcase
        end
    end

endmodule

/* hdl/clkDataRouter.sv */
`timescale 1ns/1ps

module clkDataRouter (
    input  logic  clk,
    input  logic  rst,
    regPort.slave bus,
    input  logic  iSymEn,
    input  logic  iBit,
    input  logic  qSymEn,
    input  logic  qBit,
    input  logic  trellisSymEn,
    input  logic  trellisBit,
    output logic  chClk,
    output logic  chData
);
    import demodPkg::*;

    srcSel_t sourceSelect;
    logic    selClk;
    logic    selData;

    // Source select register, lane 0 only
    always_ff @(posedge clk) begin
        if (rst) begin
            sourceSelect <= SRC_LEGACY_I;
        end else if (bus.sel && (bus.offset == 4'd0) && bus.byteWr[0]) begin
            sourceSelect <= bus.wrData[3:0];
        end
    end

    assign bus.rdData = (bus.offset == 4'd0) ? {28'd0, sourceSelect} : '0;

    always_comb begin
        case (sourceSelect)
            SRC_LEGACY_Q: begin
                selClk = qSymEn;
                selData = qBit;
            end
            SRC_PCMTRELLIS: begin
                selClk = trellisSymEn;
                selData = trellisBit;
            end
            default: begin  // Legacy I, also for unknown codes
                selClk = iSymEn;
                selData = iBit;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            chClk <= 1'b0;
            chData <= 1'b0;
        end else begin
            chClk <= selClk;
            chData <= selData;
        end
    end

endmodule

/* hdl/dacChannel.sv */
`timescale 1ns/1ps

module dacChannel (
    input  logic               clk,
    input  logic               rst,
    regPort.slave              bus,
    input  demodPkg::sample_t  demodSample,
    input  logic               demodSampleEn,
    input  demodPkg::sample_t  trellisSample,
    input  logic               trellisSampleEn,
    input  demodPkg::sample_t  adcSample,
    output demodPkg::dacCode_t dacCode
);
    import demodPkg::*;

    srcSel_t dacSource;
    sample_t selSample;
    logic    selEn;
    sample_t muxSample;
    logic    muxEn;
    sample_t holdSample;

    always_ff @(posedge clk) begin
        if (rst) begin
            dacSource <= DAC_SRC_DEMOD;
        end else if (bus.sel && (bus.offset == 4'd0) && bus.byteWr[0]) begin
            dacSource <= bus.wrData[3:0];
        end
    end

    assign bus.rdData = (bus.offset == 4'd0) ? {28'd0, dacSource} : '0;

    always_comb begin
        case (dacSource)
            DAC_SRC_FMTRELLIS: begin
                selSample = trellisSample;
                selEn = trellisSampleEn;
            end
            DAC_SRC_ADC: begin
                selSample = adcSample;
                selEn = 1'b1;       // ADC runs every clock
            end
            default: begin
                selSample = demodSample;
                selEn = demodSampleEn;
            end
        endcase
    end

    //*********************************************************************
    // Three stage pipe to the DAC pins
    //*********************************************************************
    always_ff @(posedge clk) begin
        muxSample <= selSample;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            muxEn <= 1'b0;
            holdSample <= '0;
            dacCode <= 14'h2000;    // Midscale
        end else begin
            muxEn <= selEn;
            if (muxEn) begin
                holdSample <= muxSample;
            end
            // Flip the sign for offset binary
            dacCode <= {~holdSample[17], holdSample[16:4]};
        end
    end

endmodule

/* hdl/demodOutputTop.sv */
`timescale 1ns/1ps

module demodOutputTop #(
    parameter demodPkg::busData_t VersionNumber = demodPkg::DEFAULT_VERSION
) (
    input  logic               clk,
    input  logic               rst,
    // Register bus
    input  demodPkg::regAddr_t addr,
    input  demodPkg::busData_t wrData,
    input  logic [3:0]         byteWr,
    input  logic               cs,
    output demodPkg::busData_t rdData,
    // ADC and lock status
    input  demodPkg::adcCode_t adc,
    input  logic               timingLock,
    input  logic               carrierLock,
    // Symbol streams
    input  logic               iSymEn,
    input  logic               iBit,
    input  logic               qSymEn,
    input  logic               qBit,
    input  logic               trellisSymEn,
    input  logic               trellisBit,
    // Sample streams for the DACs
    input  demodPkg::sample_t  demodSample,
    input  logic               demodSampleEn,
    input  demodPkg::sample_t  trellisSample,
    input  logic               trellisSampleEn,
    // Outputs
    output logic               ch0Clk,
    output logic               ch0Data,
    output logic               ch1Clk,
    output logic               ch1Data,
    output demodPkg::dacCode_t dac0Code,
    output demodPkg::dacCode_t dac1Code,
    output logic               lockLed0n,
    output logic               lockLed1n
);
    import demodPkg::*;

    sample_t adcSample;

    regPort topPort ();
    regPort cd0Port ();
    regPort cd1Port ();
    regPort dac0Port ();
    regPort dac1Port ();

    //*********************************************************************
    // Register bus
    //*********************************************************************
    busDecoder decoder (
        .addr(addr), .wrData(wrData), .byteWr(byteWr), .cs(cs), .rdData(rdData),
        .topPort(topPort), .cd0Port(cd0Port), .cd1Port(cd1Port),
        .dac0Port(dac0Port), .dac1Port(dac1Port)
    );

    topRegs #(.VersionNumber(VersionNumber)) regs (
        .clk(clk), .rst(rst), .bus(topPort),
        .timingLock(timingLock), .carrierLock(carrierLock),
        .lockLed0n(lockLed0n), .lockLed1n(lockLed1n)
    );

    adcReclock adcIn (.clk(clk), .adc(adc), .sample(adcSample));

    //*********************************************************************
    // Clock and data outputs
    //*********************************************************************
    clkDataRouter cAndD0 (
        .clk(clk), .rst(rst), .bus(cd0Port),
        .iSymEn(iSymEn), .iBit(iBit), .qSymEn(qSymEn), .qBit(qBit),
        .trellisSymEn(trellisSymEn), .trellisBit(trellisBit),
        .chClk(ch0Clk), .chData(ch0Data)
    );

    clkDataRouter cAndD1 (
        .clk(clk), .rst(rst), .bus(cd1Port),
        .iSymEn(iSymEn), .iBit(iBit), .qSymEn(qSymEn), .qBit(qBit),
        .trellisSymEn(trellisSymEn), .trellisBit(trellisBit),
        .chClk(ch1Clk), .chData(ch1Data)
    );

    //*********************************************************************
    // DAC channels
    //*********************************************************************
    dacChannel dac0 (
        .clk(clk), .rst(rst), .bus(dac0Port),
        .demodSample(demodSample), .demodSampleEn(demodSampleEn),
        .trellisSample(trellisSample), .trellisSampleEn(trellisSampleEn),
        .adcSample(adcSample), .dacCode(dac0Code)
    );

    dacChannel dac1 (
        .clk(clk), .rst(rst), .bus(dac1Port),
        .demodSample(demodSample), .demodSampleEn(demodSampleEn),
        .trellisSample(trellisSample), .trellisSampleEn(trellisSampleEn),
        .adcSample(adcSample), .dacCode(dac1Code)
    );

endmodule

/* hdl/demodPkg.sv */
package demodPkg;

    //*********************************************************************
    // Data widths
    //*********************************************************************
    typedef logic signed [17:0] sample_t;   // Baseband or demod sample
    typedef logic [13:0] adcCode_t;         // Offset binary from the ADC
    typedef logic [13:0] dacCode_t;         // Offset binary to the DAC
    typedef logic [12:0] regAddr_t;         // Word address, space and offset
    typedef logic [31:0] busData_t;
    typedef logic [3:0] srcSel_t;

    //*********************************************************************
    // Register address map
    //*********************************************************************
    // Upper 9 address bits pick the space
    localparam logic [8:0] TOP_SPACE    = 9'd0;
    localparam logic [8:0] CANDD0_SPACE = 9'd1;
    localparam logic [8:0] CANDD1_SPACE = 9'd2;
    localparam logic [8:0] DAC0_SPACE   = 9'd3;
    localparam logic [8:0] DAC1_SPACE   = 9'd4;

    //*********************************************************************
    // Source select codes
    //*********************************************************************
    // Clock/data channel sources
    localparam srcSel_t SRC_LEGACY_I   = 4'd0;
    localparam srcSel_t SRC_LEGACY_Q   = 4'd1;
    localparam srcSel_t SRC_PCMTRELLIS = 4'd2;

    // DAC sample sources
    localparam srcSel_t DAC_SRC_DEMOD     = 4'd0;
    localparam srcSel_t DAC_SRC_FMTRELLIS = 4'd1;
    localparam srcSel_t DAC_SRC_ADC       = 4'd2;

    localparam busData_t DEFAULT_VERSION = 32'd469;

endpackage

/* hdl/regPort.sv */
`timescale 1ns/1ps

interface regPort;
    import demodPkg::*;

    logic       sel;        // Slave select, already qualified by cs
    logic [3:0] offset;
    busData_t   wrData;
    logic [3:0] byteWr;     // One strobe per byte lane
    busData_t   rdData;

    modport decoder (output sel, offset, wrData, byteWr, input rdData);

    modport slave (input sel, offset, wrData, byteWr, output rdData);

endinterface

/* hdl/topRegs.sv */
`timescale 1ns/1ps

module topRegs #(
    parameter demodPkg::busData_t VersionNumber = demodPkg::DEFAULT_VERSION
) (
    input  logic  clk,
    input  logic  rst,
    regPort.slave bus,
    input  logic  timingLock,
    input  logic  carrierLock,
    output logic  lockLed0n,
    output logic  lockLed1n
);
    import demodPkg::*;

    busData_t   scratch;
    logic [1:0] lockReg;    // {carrier, timing}

    always_ff @(posedge clk) begin
        if (rst) begin
            scratch <= '0;
            lockReg <= 2'b00;
        end else begin
            lockReg <= {carrierLock, timingLock};
            if (bus.sel && (bus.offset == 4'd1)) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (bus.byteWr[lane]) begin
                        scratch[lane*8 +: 8] <= bus.wrData[lane*8 +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        case (bus.offset)
            4'd0:    bus.rdData = VersionNumber;
            4'd1:    bus.rdData = scratch;
            4'd2:    bus.rdData = {30'd0, lockReg};
            default: bus.rdData = '0;
        endcase
    end

    // LEDs are active low
    assign lockLed0n = ~lockReg[0];
    assign lockLed1n = ~lockReg[1];

endmodule

/* tests/demodOutputTb.sv */
`timescale 1ns/1ps

module demodOutputTb;

    localparam int ScratchLoops = 32;
    localparam int UnmappedReads = 24;
    localparam int ChanLoops = 8;
    localparam int ChanIdle = 12;
    localparam int DacLoops = 8;
    localparam int DacIdle = 12;
    localparam int AdcIdle = 24;
    localparam int LockReads = 16;
    localparam int TotalCycles = 8 + 1 + 2 * ScratchLoops + UnmappedReads
        + 2 * ChanLoops * (2 + ChanIdle) + 2 * DacLoops * (2 + DacIdle)
        + 2 + AdcIdle + LockReads + 4;

    logic        clk;
    logic        rst;
    logic [12:0] addr;
    logic [31:0] wrData;
    logic [3:0]  byteWr;
    logic        cs;
    logic [31:0] rdData;
    logic [13:0] adc;
    logic        timingLock;
    logic        carrierLock;
    logic        iSymEn;
    logic        iBit;
    logic        qSymEn;
    logic        qBit;
    logic        trellisSymEn;
    logic        trellisBit;
    logic [17:0] demodSample;
    logic        demodSampleEn;
    logic [17:0] trellisSample;
    logic        trellisSampleEn;
    logic        ch0Clk;
    logic        ch0Data;
    logic        ch1Clk;
    logic        ch1Data;
    logic [13:0] dac0Code;
    logic [13:0] dac1Code;
    logic        lockLed0n;
    logic        lockLed1n;
    int          mismatchCount;
    int          otherCount;

    tbClock clkGen (.clk(clk));

    demodOutputTop DUT (.*);

    outputScoreboard scoreboard (
        .*,
        .chClk({ch1Clk, ch0Clk}),
        .chData({ch1Data, ch0Data}),
        .dacCode({dac1Code, dac0Code}),
        .ledn({lockLed1n, lockLed0n})
    );

    function automatic logic [12:0] regAddr(input int space, input int offset);
        return {9'(space), 4'(offset)};
    endfunction

    //*********************************************************************
    // Bus tasks, one cycle each, entered 1 ns after a rising edge
    //*********************************************************************
    task automatic busWrite(input logic [12:0] a, input logic [31:0] data,
                            input logic [3:0] strobes);
        addr = a;
        wrData = data;
        byteWr = strobes;
        cs = 1'b1;
        @(posedge clk);
        #1;
        cs = 1'b0;
        byteWr = 4'd0;
    endtask

    task automatic busRead(input logic [12:0] a);
        addr = a;
        byteWr = 4'd0;
        cs = 1'b1;      // Scoreboard checks rdData mid-cycle
        @(posedge clk);
        #1;
        cs = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    // Free-running symbol, sample, ADC and lock streams
    initial begin : streamDriver
        adc = '0;
        timingLock = 1'b0;
        carrierLock = 1'b0;
        {iSymEn, iBit, qSymEn, qBit, trellisSymEn, trellisBit} = 6'd0;
        demodSample = '0;
        demodSampleEn = 1'b0;
        trellisSample = '0;
        trellisSampleEn = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            adc = 14'($urandom());
            {timingLock, carrierLock} = 2'($urandom());
            {iSymEn, iBit, qSymEn, qBit, trellisSymEn, trellisBit} = 6'($urandom());
            demodSample = 18'($urandom());
            demodSampleEn = 1'($urandom());
            trellisSample = 18'($urandom());
            trellisSampleEn = 1'($urandom());
        end
    end

    initial begin : stimulus
        void'($urandom(32'h8cdaa7d8));
        rst = 1'b1;
        addr = '0;
        wrData = '0;
        byteWr = 4'd0;
        cs = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Version, scratch lanes and unmapped reads
        busRead(regAddr(0, 0));
        for (int i = 0; i < ScratchLoops; i++) begin
            busWrite(regAddr(0, 1), $urandom(), 4'($urandom()));
            busRead(regAddr(0, 1));
        end
        for (int i = 0; i < UnmappedReads; i++) begin
            if (i % 2 == 0) busRead(regAddr(5 + $urandom_range(506), $urandom_range(15)));
            else busRead(regAddr($urandom_range(4), 3 + $urandom_range(12)));
        end

        // Channel sources, unknown codes mixed in
        for (int ch = 0; ch < 2; ch++) begin
            for (int i = 0; i < ChanLoops; i++) begin
                busWrite(regAddr(1 + ch, 0), $urandom_range(5), 4'($urandom()));
                busRead(regAddr(1 + ch, 0));
                idle(ChanIdle);
            end
        end

        // DAC sources over the demod and trellis streams
        for (int ch = 0; ch < 2; ch++) begin
            for (int i = 0; i < DacLoops; i++) begin
                busWrite(regAddr(3 + ch, 0),
                         (i % 4 == 3) ? $urandom_range(15, 3) : $urandom_range(1), 4'hf);
                busRead(regAddr(3 + ch, 0));
                idle(DacIdle);
            end
        end

        // ADC straight through both DACs
        busWrite(regAddr(3, 0), 32'd2, 4'hf);
        busWrite(regAddr(4, 0), 32'd2, 4'hf);
        idle(AdcIdle);

        repeat (LockReads) busRead(regAddr(0, 2));
        idle(4);

        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(TotalCycles * 4 + 100);
        $display("Timeout: stimulus did not finish within %0d ns", TotalCycles * 4 + 100);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* tests/outputScoreboard.sv */
`timescale 1ns/1ps

module outputScoreboard (
    input  logic             clk,
    input  logic             rst,
    input  logic [12:0]      addr,
    input  logic [31:0]      wrData,
    input  logic [3:0]       byteWr,
    input  logic             cs,
    input  logic [31:0]      rdData,
    input  logic [13:0]      adc,
    input  logic             timingLock,
    input  logic             carrierLock,
    input  logic             iSymEn,
    input  logic             iBit,
    input  logic             qSymEn,
    input  logic             qBit,
    input  logic             trellisSymEn,
    input  logic             trellisBit,
    input  logic [17:0]      demodSample,
    input  logic             demodSampleEn,
    input  logic [17:0]      trellisSample,
    input  logic             trellisSampleEn,
    input  logic [1:0]       chClk,
    input  logic [1:0]       chData,
    input  logic [1:0][13:0] dacCode,
    input  logic [1:0]       ledn,
    output int               mismatchCount,
    output int               otherCount
);
    int mismatches = 0;
    int others = 0;

    // Model state as the DUT holds it after the last rising edge
    logic [31:0] scratch;
    logic [1:0]  lockState;        // {carrier, timing}
    logic [3:0]  chSel [2];
    logic [3:0]  dacSel [2];
    logic [1:0]  expClk;
    logic [1:0]  expData;
    logic [13:0] codeLine [2][3];  // Expected DAC code per cycle with the newest in slot 0
    logic [3:0]  srcLine [2][3];
    logic [13:0] adcLine [2];      // Raw ADC words with the newest in slot 0
    bit          seenReset = 1'b0;
    bit          firstAfterReset = 1'b0;

    assign mismatchCount = mismatches;
    assign otherCount = others;

    // Zero sits at midscale so the code is the top 14 bits plus half scale
    function automatic logic [13:0] offsetBinary(input logic [17:0] s);
        return s[17:4] + 14'h2000;
    endfunction

    function automatic string readTestName(input logic [12:0] a);
        if (a == 13'h000) return "version";
        if (a == 13'h001) return "scratch";
        if (a == 13'h002) return "lockStatus";
        if (a[12:4] <= 9'd2 && a[3:0] == 4'd0) return "chanSelect";
        if (a[12:4] <= 9'd4 && a[3:0] == 4'd0) return "dacSelect";
        return "unmapped";
    endfunction

    function automatic logic [31:0] expectedRead(input logic [12:0] a);
        logic [8:0] space;
        logic [3:0] offset;
        space = a[12:4];
        offset = a[3:0];
        if (space == 9'd0) begin
            case (offset)
                4'd0:    return 32'd469;
                4'd1:    return scratch;
                4'd2:    return {30'd0, lockState};
                default: return 32'd0;
            endcase
        end
        if (offset != 4'd0) return 32'd0;
        case (space)
            9'd1:    return {28'd0, chSel[0]};
            9'd2:    return {28'd0, chSel[1]};
            9'd3:    return {28'd0, dacSel[0]};
            9'd4:    return {28'd0, dacSel[1]};
            default: return 32'd0;
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s: expected %0h, actual %0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    //*********************************************************************
    // Compare outputs against the model
    //*********************************************************************
    task automatic checkOutputs();
        logic [1:0] ledExpected;
        string      dacName;
        ledExpected = ~lockState;  // LEDs are active low
        if (firstAfterReset) begin
            compareValue("afterReset", 32'd0, 32'(chClk));
            compareValue("afterReset", 32'h2000, 32'(dacCode[0]));
            compareValue("afterReset", 32'h2000, 32'(dacCode[1]));
            compareValue("afterReset", 32'd3, 32'(ledn));
            firstAfterReset = 1'b0;
        end
        if ($isunknown({chClk, chData, dacCode, ledn})) begin
            others++;
            $display("A DUT output is unknown after reset at %0t", $time);
        end
        for (int ch = 0; ch < 2; ch++) begin
            dacName = (srcLine[ch][2] == 4'd2) ? "adcPath" : "dacPipe";
            compareValue("routing", 32'(expClk[ch]), 32'(chClk[ch]));
            compareValue("routing", 32'(expData[ch]), 32'(chData[ch]));
            compareValue(dacName, 32'(codeLine[ch][2]), 32'(dacCode[ch]));
        end
        compareValue("lockLed", 32'(ledExpected), 32'(ledn));
        if (cs) compareValue(readTestName(addr), expectedRead(addr), rdData);
    endtask

    // Next state from the inputs that the coming edge captures
    task automatic advanceModel(input logic [13:0] adcWord);
        logic [13:0] selCode;
        logic        selEn;
        logic [31:0] laneMask;
        for (int ch = 0; ch < 2; ch++) begin
            case (chSel[ch])
                4'd1: begin
                    expClk[ch] = qSymEn;
                    expData[ch] = qBit;
                end
                4'd2: begin
                    expClk[ch] = trellisSymEn;
                    expData[ch] = trellisBit;
                end
                default: begin     // Legacy I also for unknown codes
                    expClk[ch] = iSymEn;
                    expData[ch] = iBit;
                end
            endcase
            case (dacSel[ch])
                4'd1: begin
                    selCode = offsetBinary(trellisSample);
                    selEn = trellisSampleEn;
                end
                4'd2: begin
                    selCode = adcWord;     // The ADC word comes out unchanged
                    selEn = 1'b1;
                end
                default: begin
                    selCode = offsetBinary(demodSample);
                    selEn = demodSampleEn;
                end
            endcase
            codeLine[ch][2] = codeLine[ch][1];
            codeLine[ch][1] = codeLine[ch][0];
            if (selEn) codeLine[ch][0] = selCode;  // Otherwise keep the last one
            srcLine[ch][2] = srcLine[ch][1];
            srcLine[ch][1] = srcLine[ch][0];
            srcLine[ch][0] = dacSel[ch];
        end
        lockState = {carrierLock, timingLock};
        if (cs) begin
            laneMask = {{8{byteWr[3]}}, {8{byteWr[2]}}, {8{byteWr[1]}}, {8{byteWr[0]}}};
            if (addr == 13'h001) scratch = (scratch & ~laneMask) | (wrData & laneMask);
            if (byteWr[0] && addr[3:0] == 4'd0) begin
                case (addr[12:4])
                    9'd1:    chSel[0] = wrData[3:0];
                    9'd2:    chSel[1] = wrData[3:0];
                    9'd3:    dacSel[0] = wrData[3:0];
                    9'd4:    dacSel[1] = wrData[3:0];
                    default: ;
                endcase
            end
        end
    endtask

    // Mid-cycle when inputs and outputs have settled
    always @(negedge clk) begin : modelStep
        logic [13:0] adcWord;
        adcWord = adcLine[1];   // Word behind the sample the DAC mux sees now
        adcLine[1] = adcLine[0];
        adcLine[0] = adc;
        if (rst) begin
            scratch = '0;
            lockState = '0;
            expClk = '0;
            expData = '0;
            for (int ch = 0; ch < 2; ch++) begin
                chSel[ch] = 4'd0;
                dacSel[ch] = 4'd0;
                for (int k = 0; k < 3; k++) begin
                    codeLine[ch][k] = 14'h2000;
                    srcLine[ch][k] = 4'd0;
                end
            end
            seenReset = 1'b1;
            firstAfterReset = 1'b1;
        end else if (seenReset) begin
            checkOutputs();
            advanceModel(adcWord);
        end
    end

endmodule

/* tests/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter int HalfPeriodNs = 2     // 4 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HalfPeriodNs) clk = ~clk;
    end

endmodule

/* verilog.f */
hdl/demodPkg.sv
hdl/regPort.sv
hdl/busDecoder.sv
hdl/topRegs.sv
hdl/adcReclock.sv
hdl/clkDataRouter.sv
hdl/dacChannel.sv
hdl/demodOutputTop.sv
tests/tbClock.sv
tests/outputScoreboard.sv
tests/demodOutputTb.sv
